// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - design/cpuPkg.sv
      - design/pipeReg.sv
      - design/regFile.sv
      - design/hazardUnit.sv
      - design/decodeStage.sv
      - design/executeStage.sv
      - design/resultStage.sv
      - design/cpuCore.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cpuCoreTb.sv

// File: design/cpuCore.sv
`timescale 1ns/1ns
module cpuCore (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::dataWord instrData,
    input  cpuPkg::dataWord dataRData,
    output cpuPkg::dataWord instrAddr,
    output cpuPkg::dataWord dataAddr,
    output cpuPkg::dataWord dataWData,
    output logic            dataWrite
);

    cpuPkg::decodeToExec decodeOut, execIn;
    cpuPkg::execToMem execOut, memIn;
    cpuPkg::memToWb memOut, wbIn;

    cpuPkg::regAddr rs, rt, wbAddr;
    cpuPkg::dataWord rfA, rfB, memResult, wbResult;
    cpuPkg::fwdSel fwdDecodeA, fwdDecodeB, fwdExecA, fwdExecB;
    logic tUse, stall;

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .instrData(instrData),
        .fwdA(fwdDecodeA),
        .fwdB(fwdDecodeB),
        .execLink(execIn.link),
        .memResult(memResult),
        .rfA(rfA),
        .rfB(rfB),
        .instrAddr(instrAddr),
        .rs(rs),
        .rt(rt),
        .tUse(tUse),
        .toExec(decodeOut)
    );

    regFile regs (
        .clk(clk),
        .reset(reset),
        .readAddrA(rs),
        .readAddrB(rt),
        .writeAddr(wbAddr),
        .writeData(wbResult),
        .readDataA(rfA),
        .readDataB(rfB)
    );

    hazardUnit hazards (
        .clk(clk),
        .reset(reset),
        .decodeRs(rs),
        .decodeRt(rt),
        .decodeTUse(tUse),
        .execInfo(execIn),
        .memInfo(memIn),
        .wbDest(wbAddr),
        .stall(stall),
        .fwdDecodeA(fwdDecodeA),
        .fwdDecodeB(fwdDecodeB),
        .fwdExecA(fwdExecA),
        .fwdExecB(fwdExecB)
    );

    // A stall freezes fetch and decode and sends a bubble on
    pipeReg #(.payloadT(cpuPkg::decodeToExec)) execReg (
        .clk(clk),
        .reset(reset),
        .hold(1'b0),
        .bubble(stall),
        .d(decodeOut),
        .q(execIn)
    );

    executeStage execute (
        .fromDecode(execIn),
        .fwdA(fwdExecA),
        .fwdB(fwdExecB),
        .memResult(memResult),
        .wbResult(wbResult),
        .toMem(execOut)
    );

    pipeReg #(.payloadT(cpuPkg::execToMem)) memReg (
        .clk(clk),
        .reset(reset),
        .hold(1'b0),
        .bubble(1'b0),
        .d(execOut),
        .q(memIn)
    );

    resultStage result (
        .clk(clk),
        .reset(reset),
        .fromMem(memIn),
        .wbInfo(wbIn),
        .dataRData(dataRData),
        .dataAddr(dataAddr),
        .dataWData(dataWData),
        .dataWrite(dataWrite),
        .toWb(memOut),
        .memResult(memResult),
        .wbResult(wbResult),
        .wbAddr(wbAddr)
    );

    pipeReg #(.payloadT(cpuPkg::memToWb)) wbReg (
        .clk(clk),
        .reset(reset),
        .hold(1'b0),
        .bubble(1'b0),
        .d(memOut),
        .q(wbIn)
    );

endmodule

// File: design/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] dataWord;
    typedef logic [4:0] regAddr;

    // Cycles until a result can be forwarded
    typedef logic [1:0] tNew;

    localparam dataWord resetPc = 32'h0000_3000;

    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp;

    typedef enum logic [1:0] {
        srcAlu,
        srcLoad,
        srcLink
    } resultSrc;

    // Operand source, register file or a later stage
    typedef enum logic [1:0] {
        fwdRf,
        fwdExecLink,
        fwdMemResult,
        fwdWbResult
    } fwdSel;

    typedef struct packed {
        aluOp     aluCtl;
        logic     immSel;
        dataWord  imm;
        regAddr   rs;
        regAddr   rt;
        dataWord  valA;
        dataWord  valB;
        regAddr   dest;
        tNew      newCount;
        resultSrc src;
        logic     memWrite;
        logic     memRead;
        dataWord  link;
    } decodeToExec;

    typedef struct packed {
        dataWord  aluResult;
        dataWord  storeData;
        regAddr   dest;
        tNew      newCount;
        resultSrc src;
        logic     memWrite;
        logic     memRead;
        dataWord  link;
    } execToMem;

    typedef struct packed {
        regAddr   dest;
        resultSrc src;
        dataWord  aluResult;
        dataWord  link;
    } memToWb;

endpackage

// File: design/decodeStage.sv
`timescale 1ns/1ns
module decodeStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  cpuPkg::dataWord     instrData,
    input  cpuPkg::fwdSel       fwdA,
    input  cpuPkg::fwdSel       fwdB,
    input  cpuPkg::dataWord     execLink,
    input  cpuPkg::dataWord     memResult,
    input  cpuPkg::dataWord     rfA,
    input  cpuPkg::dataWord     rfB,
    output cpuPkg::dataWord     instrAddr,
    output cpuPkg::regAddr      rs,
    output cpuPkg::regAddr      rt,
    output logic                tUse,
    output cpuPkg::decodeToExec toExec
);

    cpuPkg::dataWord pc, decodePc, nextPc, heldInstr, instr, valA, valB, signImm;
    logic resetDly, stallDly;
    logic [5:0] opcode, funct;
    logic useRs, useRt, isBeq, isBne, isJal, isJr, taken;

    function automatic cpuPkg::dataWord pick(cpuPkg::fwdSel sel, cpuPkg::dataWord rf,
                                             cpuPkg::dataWord link, cpuPkg::dataWord mem);
        case (sel)
            cpuPkg::fwdExecLink:  return link;
            cpuPkg::fwdMemResult: return mem;
            default:              return rf;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        resetDly <= reset;
        heldInstr <= instr;
        if (reset) begin
            pc <= cpuPkg::resetPc;
            stallDly <= 1'b0;
        end else begin
            stallDly <= stall;
            if (!stall) begin
                pc <= nextPc;
                decodePc <= pc;
            end
        end
    end

    // Memory answers one cycle late, so a stalled word comes from the hold register
    assign instr = resetDly ? '0 : (stallDly ? heldInstr : instrData);

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign signImm = {{16{instr[15]}}, instr[15:0]};

    assign valA = pick(fwdA, rfA, execLink, memResult);
    assign valB = pick(fwdB, rfB, execLink, memResult);

    always_comb begin
        toExec = '0;
        useRs = 1'b0;
        useRt = 1'b0;
        isBeq = 1'b0;
        isBne = 1'b0;
        isJal = 1'b0;
        isJr = 1'b0;
        toExec.imm = signImm;
        case (opcode)
            cpuPkg::opRtype: begin
                useRs = 1'b1;
                useRt = 1'b1;
                toExec.dest = instr[15:11];
                toExec.newCount = 2'd1;
                case (funct)
                    cpuPkg::fnAddu: toExec.aluCtl = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: toExec.aluCtl = cpuPkg::aluSub;
                    cpuPkg::fnAnd:  toExec.aluCtl = cpuPkg::aluAnd;
                    cpuPkg::fnOr:   toExec.aluCtl = cpuPkg::aluOr;
                    cpuPkg::fnSlt:  toExec.aluCtl = cpuPkg::aluSlt;
                    cpuPkg::fnJr: begin
                        isJr = 1'b1;
                        useRt = 1'b0;
                        toExec.dest = '0;
                        toExec.newCount = 2'd0;
                    end
                    default: begin
                        useRs = 1'b0;
                        useRt = 1'b0;
                        toExec.dest = '0;
                        toExec.newCount = 2'd0;
                    end
                endcase
            end
            cpuPkg::opAddiu, cpuPkg::opOri, cpuPkg::opLui: begin
                useRs = (opcode != cpuPkg::opLui);
                toExec.immSel = 1'b1;
                toExec.dest = instr[20:16];
                toExec.newCount = 2'd1;
                if (opcode != cpuPkg::opAddiu) begin
                    toExec.imm = {16'b0, instr[15:0]};
                end
                if (opcode == cpuPkg::opOri) begin
                    toExec.aluCtl = cpuPkg::aluOr;
                end else if (opcode == cpuPkg::opLui) begin
                    toExec.aluCtl = cpuPkg::aluLui;
                end
            end
            cpuPkg::opLw: begin
                useRs = 1'b1;
                toExec.immSel = 1'b1;
                toExec.dest = instr[20:16];
                toExec.newCount = 2'd2;
                toExec.src = cpuPkg::srcLoad;
                toExec.memRead = 1'b1;
            end
            cpuPkg::opSw: begin
                useRs = 1'b1;
                useRt = 1'b1;
                toExec.immSel = 1'b1;
                toExec.memWrite = 1'b1;
            end
            cpuPkg::opBeq, cpuPkg::opBne: begin
                useRs = 1'b1;
                useRt = 1'b1;
                isBeq = (opcode == cpuPkg::opBeq);
                isBne = (opcode == cpuPkg::opBne);
            end
            cpuPkg::opJal: begin
                isJal = 1'b1;
                toExec.dest = 5'd31;
                toExec.src = cpuPkg::srcLink;
            end
            default: ;
        endcase
        toExec.rs = useRs ? instr[25:21] : '0;
        toExec.rt = useRt ? instr[20:16] : '0;
        toExec.valA = valA;
        toExec.valB = valB;
        toExec.link = decodePc + 32'd8;
    end

    assign rs = toExec.rs;
    assign rt = toExec.rt;
    assign tUse = !(isBeq || isBne || isJr);

    assign taken = (isBeq && valA == valB) || (isBne && valA != valB);

    // pc already holds the delay slot address here
    always_comb begin
        if (isJal) begin
            nextPc = {pc[31:28], instr[25:0], 2'b00};
        end else if (isJr) begin
            nextPc = valA;
        end else if (taken) begin
            nextPc = decodePc + 32'd4 + {signImm[29:0], 2'b00};
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    assign instrAddr = pc;

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ns
module executeStage (
    input  cpuPkg::decodeToExec fromDecode,
    input  cpuPkg::fwdSel       fwdA,
    input  cpuPkg::fwdSel       fwdB,
    input  cpuPkg::dataWord     memResult,
    input  cpuPkg::dataWord     wbResult,
    output cpuPkg::execToMem    toMem
);

    cpuPkg::dataWord opA, opB, aluB, aluOut;

    function automatic cpuPkg::dataWord pick(cpuPkg::fwdSel sel, cpuPkg::dataWord own,
                                             cpuPkg::dataWord mem, cpuPkg::dataWord wb);
        case (sel)
            cpuPkg::fwdMemResult: return mem;
            cpuPkg::fwdWbResult:  return wb;
            default:              return own;
        endcase
    endfunction

    assign opA = pick(fwdA, fromDecode.valA, memResult, wbResult);
    assign opB = pick(fwdB, fromDecode.valB, memResult, wbResult);
    assign aluB = fromDecode.immSel ? fromDecode.imm : opB;

    always_comb begin
        case (fromDecode.aluCtl)
            cpuPkg::aluSub: aluOut = opA - aluB;
            cpuPkg::aluAnd: aluOut = opA & aluB;
            cpuPkg::aluOr:  aluOut = opA | aluB;
            cpuPkg::aluSlt: aluOut = {31'b0, $signed(opA) < $signed(aluB)};
            cpuPkg::aluLui: aluOut = {aluB[15:0], 16'b0};
            default:        aluOut = opA + aluB;
        endcase
    end

    always_comb begin
        toMem.aluResult = aluOut;
        toMem.storeData = opB;
        toMem.dest = fromDecode.dest;
        // One stage closer to its result
        toMem.newCount = (fromDecode.newCount == 2'd0) ? 2'd0 : fromDecode.newCount - 2'd1;
        toMem.src = fromDecode.src;
        toMem.memWrite = fromDecode.memWrite;
        toMem.memRead = fromDecode.memRead;
        toMem.link = fromDecode.link;
    end

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ns
module hazardUnit (
    input  logic                clk,
    input  logic                reset,
    input  cpuPkg::regAddr      decodeRs,
    input  cpuPkg::regAddr      decodeRt,
    input  logic                decodeTUse,
    input  cpuPkg::decodeToExec execInfo,
    input  cpuPkg::execToMem    memInfo,
    input  cpuPkg::regAddr      wbDest,
    output logic                stall,
    output cpuPkg::fwdSel       fwdDecodeA,
    output cpuPkg::fwdSel       fwdDecodeB,
    output cpuPkg::fwdSel       fwdExecA,
    output cpuPkg::fwdSel       fwdExecB
);

    // Nearest producer decides, older ones are shadowed
    function automatic logic notReady(cpuPkg::regAddr src, logic tUse,
                                      cpuPkg::decodeToExec e, cpuPkg::execToMem m);
        if (src == '0) return 1'b0;
        if (src == e.dest) return e.newCount > {1'b0, tUse};
        if (src == m.dest) return m.newCount > {1'b0, tUse};
        return 1'b0;
    endfunction

    function automatic cpuPkg::fwdSel decodeFwd(cpuPkg::regAddr src,
                                                cpuPkg::decodeToExec e, cpuPkg::execToMem m);
        if (src == '0) return cpuPkg::fwdRf;
        if (src == e.dest) return (e.newCount == '0) ? cpuPkg::fwdExecLink : cpuPkg::fwdRf;
        if (src == m.dest) return (m.newCount == '0) ? cpuPkg::fwdMemResult : cpuPkg::fwdRf;
        return cpuPkg::fwdRf;
    endfunction

    function automatic cpuPkg::fwdSel execFwd(cpuPkg::regAddr src, cpuPkg::execToMem m,
                                              cpuPkg::regAddr wb);
        if (src == '0) return cpuPkg::fwdRf;
        if (src == m.dest) return m.memRead ? cpuPkg::fwdRf : cpuPkg::fwdMemResult;
        if (src == wb) return cpuPkg::fwdWbResult;
        return cpuPkg::fwdRf;
    endfunction

    assign stall = notReady(decodeRs, decodeTUse, execInfo, memInfo)
                || notReady(decodeRt, decodeTUse, execInfo, memInfo);

    assign fwdDecodeA = decodeFwd(decodeRs, execInfo, memInfo);
    assign fwdDecodeB = decodeFwd(decodeRt, execInfo, memInfo);
    assign fwdExecA   = execFwd(execInfo.rs, memInfo, wbDest);
    assign fwdExecB   = execFwd(execInfo.rt, memInfo, wbDest);

    stallNeedsProducer: assert property (
        @(posedge clk) disable iff (reset)
        stall |-> (decodeRs != '0 && (decodeRs == execInfo.dest || decodeRs == memInfo.dest))
               || (decodeRt != '0 && (decodeRt == execInfo.dest || decodeRt == memInfo.dest))
    );

    // Worst case is a load feeding a branch
    stallAtMostTwo: assert property (
        @(posedge clk) disable iff (reset) not (stall [*3])
    );

endmodule

// File: design/pipeReg.sv
`timescale 1ns/1ns
module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    hold,
    input  logic    bubble,
    input  payloadT d,
    output payloadT q
);

    // All-zero payload is a bubble, no write and no destination
    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

    holdBubbleExclusive: assert property (
        @(posedge clk) disable iff (reset) !(hold && bubble)
    );

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns
module regFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddr  readAddrA,
    input  cpuPkg::regAddr  readAddrB,
    input  cpuPkg::regAddr  writeAddr,
    input  cpuPkg::dataWord writeData,
    output cpuPkg::dataWord readDataA,
    output cpuPkg::dataWord readDataB
);

    // Register 0 has no storage
    cpuPkg::dataWord regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Writeback value goes straight through to a same-cycle read
    assign readDataA = (readAddrA == '0) ? '0 :
                       (readAddrA == writeAddr) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 :
                       (readAddrB == writeAddr) ? writeData : regs[readAddrB];

    zeroRegReadsZero: assert property (
        @(posedge clk) disable iff (reset)
        (readAddrA == '0 |-> readDataA == '0) and (readAddrB == '0 |-> readDataB == '0)
    );

endmodule

// File: design/resultStage.sv
`timescale 1ns/1ns
module resultStage (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::execToMem fromMem,
    input  cpuPkg::memToWb   wbInfo,
    input  cpuPkg::dataWord  dataRData,
    output cpuPkg::dataWord  dataAddr,
    output cpuPkg::dataWord  dataWData,
    output logic             dataWrite,
    output cpuPkg::memToWb   toWb,
    output cpuPkg::dataWord  memResult,
    output cpuPkg::dataWord  wbResult,
    output cpuPkg::regAddr   wbAddr
);

    assign dataAddr  = fromMem.aluResult;
    assign dataWData = fromMem.storeData;
    assign dataWrite = fromMem.memWrite;

    // Load data is not ready yet, the hazard unit keeps it from being used
    assign memResult = (fromMem.src == cpuPkg::srcLink) ? fromMem.link : fromMem.aluResult;

    always_comb begin
        toWb.dest = fromMem.dest;
        toWb.src = fromMem.src;
        toWb.aluResult = fromMem.aluResult;
        toWb.link = fromMem.link;
    end

    always_comb begin
        case (wbInfo.src)
            cpuPkg::srcLoad: wbResult = dataRData;
            cpuPkg::srcLink: wbResult = wbInfo.link;
            default:         wbResult = wbInfo.aluResult;
        endcase
    end

    assign wbAddr = wbInfo.dest;

    storeWordAligned: assert property (
        @(posedge clk) disable iff (reset) dataWrite |-> dataAddr[1:0] == 2'b00
    );

endmodule

// File: files.f
+incdir+tests
design/cpuPkg.sv
design/pipeReg.sv
design/regFile.sv
design/hazardUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/cpuCore.sv
tests/cpuCoreTb.sv

// File: tests/programTable.svh
localparam int programLength = 54;
localparam int storeTotal = 21;

typedef struct packed {
    cpuPkg::dataWord addr;
    cpuPkg::dataWord data;
} storeRec;

// One word per entry from resetPc
cpuPkg::dataWord programWords [programLength] = '{
    // ALU chain
    32'h3C011234,  // 0   lui   $1, 0x1234
    32'h34215678,  // 1   ori   $1, $1, 0x5678
    32'h24220100,  // 2   addiu $2, $1, 0x0100
    32'h00221821,  // 3   addu  $3, $1, $2
    32'h00232023,  // 4   subu  $4, $1, $3
    32'h00812824,  // 5   and   $5, $4, $1
    32'h00A33025,  // 6   or    $6, $5, $3
    32'h0081382A,  // 7   slt   $7, $4, $1
    32'h0024402A,  // 8   slt   $8, $1, $4
    32'hAC010000,  // 9   sw    $1, 0x00($0)
    32'hAC020004,  // 10  sw    $2, 0x04($0)
    32'hAC030008,  // 11  sw    $3, 0x08($0)
    32'hAC04000C,  // 12  sw    $4, 0x0C($0)
    32'hAC050010,  // 13  sw    $5, 0x10($0)
    32'hAC060014,  // 14  sw    $6, 0x14($0)
    32'hAC070018,  // 15  sw    $7, 0x18($0)
    32'hAC08001C,  // 16  sw    $8, 0x1C($0)
    // Load then immediate use
    32'h8C0A0080,  // 17  lw    $10, 0x80($0)
    32'h01415821,  // 18  addu  $11, $10, $1
    32'hAC0B0020,  // 19  sw    $11, 0x20($0)
    32'h8C0C0008,  // 20  lw    $12, 0x08($0)
    32'h258D0010,  // 21  addiu $13, $12, 0x10
    32'hAC0D0024,  // 22  sw    $13, 0x24($0)
    // Branches on a register written just before
    32'h240F0007,  // 23  addiu $15, $0, 7
    32'h240E0007,  // 24  addiu $14, $0, 7
    32'h11CF0002,  // 25  beq   $14, $15, +2   taken
    32'hAC0E0028,  // 26  sw    $14, 0x28($0)  delay slot
    32'hAC00002C,  // 27  sw    $0, 0x2C($0)   skipped
    32'h24100003,  // 28  addiu $16, $0, 3
    32'h120F0002,  // 29  beq   $16, $15, +2   not taken
    32'hAC10002C,  // 30  sw    $16, 0x2C($0)  delay slot
    32'hAC0F0030,  // 31  sw    $15, 0x30($0)
    32'h24110009,  // 32  addiu $17, $0, 9
    32'h162F0002,  // 33  bne   $17, $15, +2   taken
    32'hAC110034,  // 34  sw    $17, 0x34($0)  delay slot
    32'hAC000038,  // 35  sw    $0, 0x38($0)   skipped
    32'h24120007,  // 36  addiu $18, $0, 7
    32'h164F0002,  // 37  bne   $18, $15, +2   not taken
    32'hAC120038,  // 38  sw    $18, 0x38($0)  delay slot
    32'hAC11003C,  // 39  sw    $17, 0x3C($0)
    32'h8C130028,  // 40  lw    $19, 0x28($0)
    32'h126F0002,  // 41  beq   $19, $15, +2   taken after two stalls
    32'hAC130040,  // 42  sw    $19, 0x40($0)  delay slot
    32'hAC000044,  // 43  sw    $0, 0x44($0)   skipped
    // Call and return
    32'h0C000C32,  // 44  jal   0x30C8
    32'hAC1F0044,  // 45  sw    $31, 0x44($0)  delay slot
    32'hAC010050,  // 46  sw    $1, 0x50($0)   return point
    32'h1000FFFF,  // 47  beq   $0, $0, -1     self loop
    32'h00000000,  // 48  nop
    32'h00000000,  // 49  nop
    32'h24140055,  // 50  addiu $20, $0, 0x55
    32'hAC140048,  // 51  sw    $20, 0x48($0)
    32'h03E00008,  // 52  jr    $31
    32'hAC1F004C   // 53  sw    $31, 0x4C($0)  delay slot
};

// Address, data
storeRec expectedStores [storeTotal] = '{
    '{32'h00, 32'h12345678}, '{32'h04, 32'h12345778}, '{32'h08, 32'h2468ADF0},
    '{32'h0C, 32'hEDCBA888}, '{32'h10, 32'h00000008}, '{32'h14, 32'h2468ADF8},
    '{32'h18, 32'h00000001}, '{32'h1C, 32'h00000000}, '{32'h20, 32'hB7D956F8},
    '{32'h24, 32'h2468AE00}, '{32'h28, 32'h00000007}, '{32'h2C, 32'h00000003},
    '{32'h30, 32'h00000007}, '{32'h34, 32'h00000009}, '{32'h38, 32'h00000007},
    '{32'h3C, 32'h00000009}, '{32'h40, 32'h00000007}, '{32'h44, 32'h000030B8},
    '{32'h48, 32'h00000055}, '{32'h4C, 32'h000030B8}, '{32'h50, 32'h12345678}
};

// File: tests/cpuCoreTb.sv
`timescale 1ns/1ns
module cpuCoreTb;

    `include "programTable.svh"

    localparam int resetCycles = 10;
    localparam int cycleLimit = 4 * programLength + 50;
    // Quiet cycles after the last store to catch extra ones
    localparam int drainCycles = 10;

    logic clk;
    logic reset;
    cpuPkg::dataWord instrData;
    cpuPkg::dataWord dataRData;
    cpuPkg::dataWord instrAddr;
    cpuPkg::dataWord dataAddr;
    cpuPkg::dataWord dataWData;
    logic dataWrite;

    cpuPkg::dataWord instrMem [256];
    cpuPkg::dataWord dataMem [64];
    cpuPkg::dataWord instrOffset;

    int storeCount = 0;
    int cycleCount = 0;

    cpuCore DUT (
        .clk(clk),
        .reset(reset),
        .instrData(instrData),
        .dataRData(dataRData),
        .instrAddr(instrAddr),
        .dataAddr(dataAddr),
        .dataWData(dataWData),
        .dataWrite(dataWrite)
    );

    always #20 clk = ~clk;

    // Unused words carry their index under an unsupported opcode, so they decode as nops
    function automatic cpuPkg::dataWord nopFiller(int index);
        logic [7:0] low;
        low = index[7:0];
        return {6'h3f, 18'h0, low};
    endfunction

    function automatic cpuPkg::dataWord dataPattern(int index);
        logic [5:0] low;
        low = index[5:0];
        return {16'hA5A5, 8'h00, low, 2'b00};
    endfunction

    task automatic loadMemories();
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = (i < programLength) ? programWords[i] : nopFiller(i);
        end
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = dataPattern(i);
        end
    endtask

    task automatic failAndStop();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        failAndStop();
    endtask

    task automatic valueMismatch(input string name, input cpuPkg::dataWord got,
                                 input cpuPkg::dataWord expected);
        $display("ERR t=%0t %s got %h expected %h", $time, name, got, expected);
        failAndStop();
    endtask

    task automatic expectIdle();
        assert (dataWrite == 1'b0)
            else valueMismatch("dataWrite", {31'b0, dataWrite}, 32'h0);
        assert (instrAddr == cpuPkg::resetPc)
            else valueMismatch("instrAddr", instrAddr, cpuPkg::resetPc);
    endtask

    task automatic matchStore();
        storeRec expected;
        assert (storeCount < storeTotal)
            else abortRun("A store arrived after the last expected store");
        expected = expectedStores[storeCount];
        assert (dataAddr == expected.addr)
            else valueMismatch("dataAddr", dataAddr, expected.addr);
        assert (dataWData == expected.data)
            else valueMismatch("dataWData", dataWData, expected.data);
        storeCount++;
    endtask

    // Both memories answer one cycle after the request
    assign instrOffset = instrAddr - cpuPkg::resetPc;

    always @(posedge clk) begin
        instrData <= instrMem[instrOffset[9:2]];
    end

    always @(posedge clk) begin
        if (dataWrite) begin
            dataMem[dataAddr[7:2]] <= dataWData;
        end
        dataRData <= dataMem[dataAddr[7:2]];
    end

    always @(negedge clk) begin
        if (!reset && dataWrite) begin
            matchStore();
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            abortRun($sformatf("Timeout, only %0d of %0d stores arrived",
                               storeCount, storeTotal));
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instrData = '0;
        dataRData = '0;
        loadMemories();
        repeat (resetCycles) begin
            @(negedge clk);
            expectIdle();
        end
        reset = 1'b0;
        wait (storeCount == storeTotal);
        repeat (drainCycles) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
